// ==== dv/cache_dir_input.txt ====
// columns: addr (hex, {tag, line}), expected hit, expected way, idle cycles before
// 4 ways, 8 lines, 5-bit tag, tree replacement
// line 0, cold misses fill ways 0, 2, 1, 3
08 0 0 1
10 0 2 1
18 0 1 1
20 0 3 1
// hit way 0, next victim is way 2
08 1 0 1
28 0 2 1
// evicted tag 2 misses again
10 0 1 1
28 1 2 1
18 0 0 1
20 1 3 1
08 0 1 1
// line 5 with the same tags keeps its own state
0d 0 0 1
15 0 2 1
0d 1 0 1
// line 0 unchanged by line 5 traffic
18 1 0 1
20 1 3 1
35 0 3 1
3d 0 1 1
15 1 2 1
// line 3, requests on every cycle
0b 0 0 1
13 0 2 0
0b 1 0 0
1b 0 3 0
23 0 1 0
1b 1 3 0
2b 0 0 0
// fill then hit on the very next cycle
2b 1 0 0
0b 0 2 0
13 0 1 0
// mixed lines, hits then evictions on line 0
18 1 0 2
3d 1 1 1
28 1 2 0
35 1 3 0
10 0 1 1
08 0 3 0
20 0 0 0

// ==== flist.f ====
logic/cache_dir_pkg.sv
logic/onehot_to_bin.sv
logic/line_regfile.sv
logic/replacement_policy.sv
logic/tag_store.sv
logic/cache_dir.sv
dv/cache_dir_tb.sv

// ==== Makefile ====
SIM     := verilator
FLAGS   := --binary --timing --assert --timescale 1ns/1ns
TOP     := cache_dir_tb
FLIST   := flist.f
OBJ_DIR := obj_dir

.PHONY: sim clean

# pass only when the run prints the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/cache_dir_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

// directed test of the cache tag directory
// requests and expected responses come from dv/cache_dir_input.txt
module cache_dir_tb import cache_dir_pkg::*;;

   localparam int n_ways   = 4;
   localparam int nlines_w = 3;
   localparam int tag_w    = 5;
   localparam int addr_w   = tag_w + nlines_w;
   localparam int max_wait = 20;  // cycles allowed for one response

   logic              clk;
   logic              rst_n;
   logic              req;
   logic [addr_w-1:0] addr;
   logic              resp_valid;
   logic              hit;
   logic [1:0]        way;

   // one entry per request line of the input file
   int vec_addr [$];
   int vec_hit  [$];
   int vec_way  [$];
   int vec_gap  [$];  // idle cycles before the request
   int req_num;       // request being checked, counted from 1

   cache_dir #(
      .n_ways     (n_ways),
      .nlines_w   (nlines_w),
      .tag_w      (tag_w),
      .rep_policy (rep_plru_tree)
   ) u_cache_dir (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .addr       (addr),
      .resp_valid (resp_valid),
      .hit        (hit),
      .way        (way)
   );

   always #4 clk = ~clk;  // 8 ns period

   task automatic stop_run();
      $display("TEST FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail %s at request %0d: got 0x%0h, expected 0x%0h",
                  name, req_num, got, exp);
         stop_run();
      end
   endtask

   // comment and blank lines scan fewer than four fields and are skipped
   task automatic read_vectors();
      int    fd;
      int    n;
      int    a;
      int    h;
      int    w;
      int    g;
      string line;
      fd = $fopen("dv/cache_dir_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the input file dv/cache_dir_input.txt");
         stop_run();
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
               n = $sscanf(line, "%h %h %h %d", a, h, w, g);
               if (n == 4) begin
                  vec_addr.push_back(a);
                  vec_hit.push_back(h);
                  vec_way.push_back(w);
                  vec_gap.push_back(g);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // req drops right after the edge that took it
   task automatic wait_response();
      int cnt;
      cnt = 0;
      do begin
         @(posedge clk);
         #1;
         req = 1'b0;
         cnt++;
      end while (!resp_valid && cnt < max_wait);
      if (!resp_valid) begin
         $display("no response to request %0d within %0d cycles", req_num, max_wait);
         stop_run();
      end
   endtask

   initial begin
      clk     = 1'b0;
      rst_n   = 1'b0;
      req     = 1'b0;
      addr    = '0;
      req_num = 0;
      read_vectors();

      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_value("resp_valid", 32'(resp_valid), 32'd0);  // quiet out of reset
      check_value("hit", 32'(hit), 32'd0);

      for (int i = 0; i < vec_addr.size(); i++) begin
         req_num = i + 1;
         for (int c = 0; c < vec_gap[i]; c++) begin
            @(posedge clk);
            #1;
            check_value("resp_valid", 32'(resp_valid), 32'd0);  // pulse is one cycle
         end
         // a gap of 0 sends this request on the cycle after the last one
         req  = 1'b1;
         addr = addr_w'(vec_addr[i]);
         wait_response();
         check_value("hit", 32'(hit), 32'(vec_hit[i]));
         check_value("way", 32'(way), 32'(vec_way[i]));
      end

      if (vec_addr.size() == 0) begin
         $display("the input file holds no requests");
         stop_run();
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== logic/cache_dir.sv ====
`timescale 1ns/1ns
`default_nettype none

// cache tag directory top, lookup on req, response one cycle later
module cache_dir import cache_dir_pkg::*; #(
   parameter int          n_ways     = 4,
   parameter int          nlines_w   = 3,
   parameter int          tag_w      = 5,
   parameter rep_policy_t rep_policy = rep_plru_tree,
   localparam int         way_w      = clog2_min1(n_ways)
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      req,         // one-cycle strobe
   input  logic [tag_w+nlines_w-1:0] addr,        // {tag, line index}
   output logic                      resp_valid,  // one-cycle pulse
   output logic                      hit,
   output logic [way_w-1:0]          way
);

   logic [nlines_w-1:0] line_idx;
   logic [tag_w-1:0]    req_tag;
   logic [n_ways-1:0]   way_hit;         // from the tag compare
   logic [n_ways-1:0]   way_select;      // victim, one-hot
   logic [way_w-1:0]    way_select_bin;
   logic [way_w-1:0]    hit_bin;
   logic [n_ways-1:0]   upd_vec;         // way the policy marks as used
   logic                lookup_hit;
   logic                alloc;

   assign line_idx = addr[nlines_w-1:0];
   assign req_tag  = addr[tag_w+nlines_w-1:nlines_w];

   assign lookup_hit = |way_hit;
   assign alloc      = req & ~lookup_hit;                 // miss fills the victim
   assign upd_vec    = lookup_hit ? way_hit : way_select;

   tag_store #(
      .n_ways   (n_ways),
      .nlines_w (nlines_w),
      .tag_w    (tag_w)
   ) u_tag_store (
      .clk       (clk),
      .rst_n     (rst_n),
      .line_idx  (line_idx),
      .req_tag   (req_tag),
      .alloc     (alloc),
      .alloc_way (way_select),
      .way_hit   (way_hit)
   );

   replacement_policy #(
      .n_ways     (n_ways),
      .nlines_w   (nlines_w),
      .rep_policy (rep_policy)
   ) u_rep_policy (
      .clk            (clk),
      .rst_n          (rst_n),
      .write_en       (req),        // every request touches the policy
      .way_hit        (upd_vec),
      .line_addr      (line_idx),
      .way_select     (way_select),
      .way_select_bin (way_select_bin)
   );

   onehot_to_bin #(
      .way_w (way_w)
   ) u_hit_bin (
      .onehot (way_hit[n_ways-1:1]),
      .bin    (hit_bin)
   );

   // response control
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         resp_valid <= 1'b0;
         hit        <= 1'b0;
      end else begin
         resp_valid <= req;
         if (req) begin
            hit <= lookup_hit;  // held until the next response
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req) begin
         way <= lookup_hit ? hit_bin : way_select_bin;  // hit way or filled way
      end
   end

   // a miss fills the victim on the same edge it is reported, so the same
   // address asked for right after must hit in exactly that way
   a_alloc_then_hit: assert property (
      @(posedge clk) disable iff (!rst_n)
      alloc ##1 (req && (addr == $past(addr))) |->
         (lookup_hit && (way_hit == $past(way_select)))
   );

endmodule

`default_nettype wire

// ==== logic/tag_store.sv ====
`timescale 1ns/1ns
`default_nettype none

// tag and valid arrays, parallel compare over all ways of one line
module tag_store import cache_dir_pkg::*; #(
   parameter int  n_ways   = 4,
   parameter int  nlines_w = 3,
   parameter int  tag_w    = 5,
   localparam int way_w    = clog2_min1(n_ways)
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [nlines_w-1:0] line_idx,
   input  logic [tag_w-1:0]    req_tag,
   input  logic                alloc,      // miss, write the tag into alloc_way
   input  logic [n_ways-1:0]   alloc_way,  // one-hot victim
   output logic [n_ways-1:0]   way_hit
);

   localparam int n_lines = 1 << nlines_w;

   logic [tag_w-1:0]                tag_mem [n_ways][n_lines];
   logic [n_ways-1:0][n_lines-1:0] valid_q;  // cleared only by reset
   logic [way_w:0]                  hit_cnt;  // matching ways at this line

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else if (alloc) begin
         for (int w = 0; w < n_ways; w++) begin
            if (alloc_way[w]) begin
               valid_q[w][line_idx] <= 1'b1;
            end
         end
      end
   end

   // tag payload, meaningless until its valid bit is set
   always_ff @(posedge clk) begin
      if (alloc) begin
         for (int w = 0; w < n_ways; w++) begin
            if (alloc_way[w]) begin
               tag_mem[w][line_idx] <= req_tag;
            end
         end
      end
   end

   always_comb begin
      for (int w = 0; w < n_ways; w++) begin
         way_hit[w] = valid_q[w][line_idx] && (tag_mem[w][line_idx] == req_tag);
      end
   end

   always_comb begin
      hit_cnt = '0;
      for (int w = 0; w < n_ways; w++) begin
         hit_cnt = hit_cnt + {{way_w{1'b0}}, way_hit[w]};
      end
   end

   // allocation only happens on a miss, so a tag should never live in two
   // ways of one line; a second copy means the miss path and victim disagree
   a_hit_unique: assert property (
      @(posedge clk) disable iff (!rst_n)
      hit_cnt <= 1
   );

endmodule

`default_nettype wire

// ==== logic/replacement_policy.sv ====
`timescale 1ns/1ns
`default_nettype none

// per-line replacement state and victim choice
// victim is a function of stored state only, the update vector never feeds it
module replacement_policy import cache_dir_pkg::*; #(
   parameter int          n_ways     = 4,
   parameter int          nlines_w   = 3,
   parameter rep_policy_t rep_policy = rep_plru_tree,
   localparam int         way_w      = clog2_min1(n_ways)
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                write_en,
   input  logic [n_ways-1:0]   way_hit,         // one-hot way being used
   input  logic [nlines_w-1:0] line_addr,
   output logic [n_ways-1:0]   way_select,      // one-hot victim
   output logic [way_w-1:0]    way_select_bin
);

   if (rep_policy == rep_lru) begin : g_lru
      // ranks run 0 (least recent) to n_ways-1 (most recent)
      logic [n_ways-1:0][way_w-1:0] rank_q;    // as stored
      logic [n_ways-1:0][way_w-1:0] rank;      // with the reset default applied
      logic [n_ways-1:0][way_w-1:0] rank_d;
      logic [way_w-1:0]             used_bin;
      logic [way_w-1:0]             used_rank;

      onehot_to_bin #(
         .way_w (way_w)
      ) u_used_bin (
         .onehot (way_hit[n_ways-1:1]),
         .bin    (used_bin)
      );

      // all-zero state stands for ranks equal to way numbers
      // a live state is a permutation, so it is never all zero
      always_comb begin
         for (int i = 0; i < n_ways; i++) begin
            rank[i] = (|rank_q) ? rank_q[i] : way_w'(i);
         end
      end

      assign used_rank = rank[used_bin];

      always_comb begin
         rank_d = rank_q;  // no way used, state stays
         if (|way_hit) begin
            for (int i = 0; i < n_ways; i++) begin
               if (way_hit[i]) begin
                  rank_d[i] = '1;  // used way becomes most recent
               end else if (rank[i] > used_rank) begin
                  rank_d[i] = rank[i] - 1'b1;  // close the gap it left
               end else begin
                  rank_d[i] = rank[i];
               end
            end
         end
      end

      for (genvar i = 0; i < n_ways; i++) begin : g_sel
         assign way_select[i] = (rank[i] == '0);  // rank zero is the victim
      end

      line_regfile #(
         .addr_w (nlines_w),
         .data_w (n_ways * way_w)
      ) u_rank_mem (
         .clk    (clk),
         .rst_n  (rst_n),
         .we     (write_en),
         .addr   (line_addr),
         .w_data (rank_d),
         .r_data (rank_q)
      );

      onehot_to_bin #(
         .way_w (way_w)
      ) u_victim_bin (
         .onehot (way_select[n_ways-1:1]),
         .bin    (way_select_bin)
      );

   end else if (rep_policy == rep_plru_mru) begin : g_mru
      logic [n_ways-1:0] mru_q;
      logic [n_ways-1:0] mru_d;
      logic [n_ways-1:0] mru_set;

      assign mru_set = mru_q | way_hit;
      // all bits set would leave no victim, restart with just the used way
      assign mru_d = (&mru_set) ? way_hit : mru_set;

      assign way_select[0] = ~mru_q[0];
      for (genvar i = 1; i < n_ways; i++) begin : g_sel
         // lowest clear bit wins
         assign way_select[i] = ~mru_q[i] & (&mru_q[i-1:0]);
      end

      line_regfile #(
         .addr_w (nlines_w),
         .data_w (n_ways)
      ) u_mru_mem (
         .clk    (clk),
         .rst_n  (rst_n),
         .we     (write_en),
         .addr   (line_addr),
         .w_data (mru_d),
         .r_data (mru_q)
      );

      onehot_to_bin #(
         .way_w (way_w)
      ) u_victim_bin (
         .onehot (way_select[n_ways-1:1]),
         .bin    (way_select_bin)
      );

   end else begin : g_tree
      // heap numbering, root is node 1, children of k are 2k and 2k+1
      // leaves n_ways..2*n_ways-1 map to ways 0..n_ways-1
      logic [n_ways-1:1] tree_q;
      logic [n_ways-1:1] tree_d;
      logic [way_w:0]    node;   // node reached while walking down

      always_comb begin
         node = (way_w + 1)'(1);
         for (int l = 0; l < way_w; l++) begin
            node = {node[way_w-1:0], tree_q[node[way_w-1:0]]};  // 0 left, 1 right
         end
      end

      assign way_select_bin = node[way_w-1:0];  // leaf id minus n_ways
      assign way_select     = n_ways'(1) << way_select_bin;

      for (genvar l = 1; l <= way_w; l++) begin : g_level
         for (genvar j = 0; j < (1 << (l - 1)); j++) begin : g_node
            localparam int k        = (1 << (l - 1)) + j;
            localparam int span     = n_ways >> l;                       // ways per child
            localparam int left_lo  = ((2 * k) << (way_w - l)) - n_ways;
            localparam int right_lo = left_lo + span;

            // point away from the used side, untouched subtrees keep their bit
            assign tree_d[k] = (|way_hit[left_lo +: span]) |
                               (tree_q[k] & ~(|way_hit[right_lo +: span]));
         end
      end

      line_regfile #(
         .addr_w (nlines_w),
         .data_w (n_ways - 1)
      ) u_tree_mem (
         .clk    (clk),
         .rst_n  (rst_n),
         .we     (write_en),
         .addr   (line_addr),
         .w_data (tree_d),
         .r_data (tree_q)
      );
   end

   if (rep_policy != rep_plru_tree) begin : g_onehot_chk
      // rank or mru state written over many updates must decode to exactly one victim
      a_victim_onehot: assert property (
         @(posedge clk) disable iff (!rst_n)
         $onehot(way_select)
      );
   end

   // a way just used is never the next victim at the same line
   a_victim_not_used: assert property (
      @(posedge clk) disable iff (!rst_n)
      write_en ##1 (line_addr == $past(line_addr)) |->
         !(|(way_select & $past(way_hit)))
   );

endmodule

`default_nettype wire

// ==== logic/line_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

// one word per cache line, read is combinational, write lands on the edge
module line_regfile #(
   parameter int addr_w = 3,
   parameter int data_w = 8
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              we,
   input  logic [addr_w-1:0] addr,
   input  logic [data_w-1:0] w_data,
   output logic [data_w-1:0] r_data
);

   localparam int depth = 1 << addr_w;

   logic [data_w-1:0] mem [depth];  // policy state, one entry per line

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // zero state is the defined start point of every policy
         for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[addr] <= w_data;  // read-modify-write of the addressed line
      end
   end

   assign r_data = mem[addr];  // same address feeds the read and the write

   // an unknown line index on a write would smear state across lines
   // and only show up many requests later as a wrong victim
   a_addr_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      we |-> !$isunknown(addr)
   );

endmodule

`default_nettype wire

// ==== logic/onehot_to_bin.sv ====
`timescale 1ns/1ns
`default_nettype none

// one-hot way vector to binary way number
// bit 0 of the vector is not needed, way 0 encodes as all zeros
module onehot_to_bin #(
   parameter int way_w = 2
) (
   input  logic [(1 << way_w)-1:1] onehot,  // upper bits of the one-hot vector
   output logic [way_w-1:0]        bin
);

   always_comb begin
      bin = '0;
      // every set position ORs its own index into the result
      for (int i = 1; i < (1 << way_w); i++) begin
         if (onehot[i]) begin
            bin = bin | way_w'(i);
         end
      end
   end

   // an all-zero input falls through as way 0, which is what
   // the hit path wants when there is no hit at all

endmodule

`default_nettype wire

// ==== logic/cache_dir_pkg.sv ====
`default_nettype none

// shared definitions for the cache tag directory
package cache_dir_pkg;

   // replacement policy codes, picked per build through the rep_policy parameter
   typedef enum logic [1:0] {
      rep_lru       = 2'd0,  // true lru, one rank per way
      rep_plru_mru  = 2'd1,  // pseudo lru, one mru bit per way
      rep_plru_tree = 2'd2   // pseudo lru, binary tree of node bits
   } rep_policy_t;

   // field width for n values, never below one bit
   // a one-way set still needs a way field to hang ports on
   function automatic int clog2_min1(input int n);
      int w;
      w = $clog2(n);
      if (w < 1) begin
         w = 1;
      end
      return w;
   endfunction

endpackage

`default_nettype wire
